// File: htif_bus_pkg.sv
package htif_bus_pkg;

  // processor-side register port types
  localparam int WORD_W = 32;
  localparam int ADDR_W = 32;
  localparam int ID_W   = 12;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] bus_addr_t;
  typedef logic [ID_W-1:0]   bus_id_t;
  typedef logic [4:0]        reg_sel_t;  // byte address bits 6..2

  // read side register map
  localparam reg_sel_t REG_COUNT   = 5'h00;  // host-out word count
  localparam reg_sel_t REG_FIFO_RD = 5'h01;  // pops oldest host-out word

  // write side register map
  localparam reg_sel_t REG_FIFO_WR = 5'h00;  // pushes a host-in word
  localparam reg_sel_t REG_RESET   = 5'h1f;  // core reset pulse

endpackage

// File: htif_host_pkg.sv
package htif_host_pkg;

  // host channel moves 16-bit halves of a bus word
  localparam int HALF_W = 16;

  typedef logic [HALF_W-1:0] half_t;

  localparam int HALVES_PER_WORD = 2;

  // index of a half within its word, low half first
  localparam int HALF_SEL_W = $clog2(HALVES_PER_WORD);

  typedef logic [HALF_SEL_W-1:0] half_sel_t;

  localparam half_sel_t LAST_HALF = half_sel_t'(HALVES_PER_WORD - 1);

endpackage

// File: host_out_rd_if.sv
interface host_out_rd_if
  import htif_bus_pkg::*;
#(
  parameter int DEPTH = 32,
  localparam int CNT_W = $clog2(DEPTH) + 1
)
();
  logic             rd_en;    // pop request from the register side
  word_t            rd_data;  // oldest packed word
  logic [CNT_W-1:0] count;
  logic             empty;

  modport ctrl (output rd_en, input rd_data, count, empty);
  modport path (input rd_en, output rd_data, count, empty);
endinterface

// File: sync_fifo.sv
module sync_fifo
  import htif_bus_pkg::*;
#(
  parameter int DEPTH = 32,
  localparam int CNT_W = $clog2(DEPTH) + 1
)
(
  input  logic             clk,
  input  logic             reset,
  input  logic             wr_en,
  input  word_t            wr_data,
  input  logic             rd_en,
  output word_t            rd_data,
  output logic             empty,
  output logic             full,
  output logic [CNT_W-1:0] count
);
  localparam int PTR_W = $clog2(DEPTH);

  word_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_wr;
  logic             do_rd;
  logic [CNT_W-1:0] count_next;

  assign do_wr   = wr_en && !full;   // dropped when full
  assign do_rd   = rd_en && !empty;
  assign rd_data = mem[rd_ptr];      // head word, shown without a pop

  always_comb
  begin
    count_next = count;
    if (do_wr && !do_rd)
      count_next = count + 1'b1;
    else if (do_rd && !do_wr)
      count_next = count - 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      empty  <= 1'b1;
      full   <= 1'b0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;  // wraps, DEPTH is a power of two
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count_next;
      empty <= (count_next == '0);
      full  <= (count_next == CNT_W'(DEPTH));
    end
  end

  always_ff @(posedge clk)
  begin
    if (do_wr)
      mem[wr_ptr] <= wr_data;
  end

  a_count_bound: assert property (@(posedge clk) disable iff (reset)
    count <= CNT_W'(DEPTH));
  a_ptr_count: assert property (@(posedge clk) disable iff (reset)
    (wr_ptr - rd_ptr) == count[PTR_W-1:0]);  // pointers agree with the count
endmodule

// File: host_in_unpacker.sv
module host_in_unpacker
  import htif_bus_pkg::*, htif_host_pkg::*;
#(
  parameter int DEPTH = 32
)
(
  input  logic  clk,
  input  logic  reset,
  input  logic  wr_en,
  input  word_t wr_data,
  input  logic  host_in_ready,
  output logic  full,
  output logic  host_in_valid,
  output half_t host_in_bits
);
  word_t     head;
  logic      empty;
  logic      xfer;
  logic      pop;
  half_sel_t half_sel;  // which half of the head word is on the channel

  sync_fifo #(.DEPTH(DEPTH)) u_fifo (
    .clk     (clk),
    .reset   (reset),
    .wr_en   (wr_en),
    .wr_data (wr_data),
    .rd_en   (pop),
    .rd_data (head),
    .empty   (empty),
    .full    (full),
    .count   ()
  );

  assign host_in_valid = !empty;
  assign host_in_bits  = head[HALF_W*half_sel +: HALF_W];  // low half first
  assign xfer          = host_in_valid && host_in_ready;
  assign pop           = xfer && (half_sel == LAST_HALF);

  always_ff @(posedge clk)
  begin
    if (reset)
      half_sel <= '0;
    else if (xfer)
      half_sel <= (half_sel == LAST_HALF) ? '0 : half_sel + 1'b1;
  end
endmodule

// File: host_out_packer.sv
module host_out_packer
  import htif_bus_pkg::*, htif_host_pkg::*;
#(
  parameter int DEPTH = 32
)
(
  input  logic  clk,
  input  logic  reset,
  input  logic  host_out_valid,
  input  half_t host_out_bits,
  output logic  host_out_ready,
  host_out_rd_if.path rd
);
  half_t     first_half;  // low half waiting for its partner
  half_sel_t half_idx;
  logic      full;
  logic      xfer;
  logic      push;

  assign host_out_ready = !full;
  assign xfer           = host_out_valid && host_out_ready;
  assign push           = xfer && (half_idx == LAST_HALF);  // only on the accepted high half

  sync_fifo #(.DEPTH(DEPTH)) u_fifo (
    .clk     (clk),
    .reset   (reset),
    .wr_en   (push),
    .wr_data ({host_out_bits, first_half}),
    .rd_en   (rd.rd_en),
    .rd_data (rd.rd_data),
    .empty   (rd.empty),
    .full    (full),
    .count   (rd.count)
  );

  always_ff @(posedge clk)
  begin
    if (reset)
      half_idx <= '0;
    else if (xfer)
      half_idx <= (half_idx == LAST_HALF) ? '0 : half_idx + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (xfer && half_idx != LAST_HALF)
      first_half <= host_out_bits;
  end
endmodule

// File: htif_reg_ctrl.sv
module htif_reg_ctrl
  import htif_bus_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  // write address and data
  input  logic      aw_valid,
  output logic      aw_ready,
  input  bus_addr_t aw_addr,
  input  bus_id_t   aw_id,
  input  logic      w_valid,
  output logic      w_ready,
  input  word_t     w_data,
  // write response
  output logic      b_valid,
  input  logic      b_ready,
  output bus_id_t   b_id,
  // read address and data
  input  logic      ar_valid,
  output logic      ar_ready,
  input  bus_addr_t ar_addr,
  input  bus_id_t   ar_id,
  output logic      r_valid,
  input  logic      r_ready,
  output word_t     r_data,
  output bus_id_t   r_id,
  output logic      r_last,
  // host-in queue write side
  output logic      in_wr_en,
  output word_t     in_wr_data,
  input  logic      in_full,
  output logic      cpu_reset,
  host_out_rd_if.ctrl out_rd
);
  typedef enum logic [1:0] {WR_IDLE, WR_ACCEPT, WR_RESP} wr_state_t;
  typedef enum logic {RD_IDLE, RD_DATA} rd_state_t;

  wr_state_t wr_state;
  rd_state_t rd_state;
  reg_sel_t  wr_sel;
  reg_sel_t  rd_sel;
  logic      wr_accept;

  // reset register never waits on the queue
  assign wr_accept = (wr_state == WR_ACCEPT) && (!in_full || wr_sel == REG_RESET);

  assign aw_ready   = wr_accept;
  assign w_ready    = wr_accept;
  assign in_wr_en   = wr_accept && (wr_sel == REG_FIFO_WR);
  assign in_wr_data = w_data;
  assign cpu_reset  = wr_accept && (wr_sel == REG_RESET);
  assign b_valid    = (wr_state == WR_RESP);

  assign ar_ready = (rd_state == RD_IDLE);
  assign r_valid  = (rd_state == RD_DATA);
  assign r_last   = (rd_state == RD_DATA);  // single beat reads
  assign r_data   = (rd_sel == REG_COUNT) ? word_t'(out_rd.count) : out_rd.rd_data;

  // pop only on the data register handshake
  assign out_rd.rd_en = r_valid && r_ready && (rd_sel == REG_FIFO_RD) && !out_rd.empty;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_state <= WR_IDLE;
      rd_state <= RD_IDLE;
    end
    else
    begin
      case (wr_state)
        WR_IDLE:
          if (aw_valid && w_valid)
            wr_state <= WR_ACCEPT;
        WR_ACCEPT:
          if (wr_accept)
            wr_state <= WR_RESP;
        WR_RESP:
          if (b_ready)
            wr_state <= WR_IDLE;
        default:
          wr_state <= WR_IDLE;
      endcase

      case (rd_state)
        RD_IDLE:
          if (ar_valid)
            rd_state <= RD_DATA;
        RD_DATA:
          if (r_ready)
            rd_state <= RD_IDLE;
        default:
          rd_state <= RD_IDLE;
      endcase
    end
  end

  // index and ID capture
  always_ff @(posedge clk)
  begin
    if (wr_state == WR_IDLE && aw_valid && w_valid)
    begin
      wr_sel <= aw_addr[6:2];
      b_id   <= aw_id;
    end
    if (ar_ready && ar_valid)
    begin
      rd_sel <= ar_addr[6:2];
      r_id   <= ar_id;
    end
  end

  a_wr_req_held: assert property (@(posedge clk) disable iff (reset)
    aw_ready |-> aw_valid && w_valid);  // request still up when it is taken
  a_r_held: assert property (@(posedge clk) disable iff (reset)
    r_valid && !r_ready && rd_sel != REG_COUNT && !out_rd.empty
      |=> r_valid && $stable(r_data));
endmodule

// File: htif_bridge.sv
module htif_bridge
  import htif_bus_pkg::*, htif_host_pkg::*;
#(
  parameter int DEPTH = 32
)
(
  input  logic      clk,
  input  logic      reset,
  // write address channel
  input  logic      aw_valid,
  output logic      aw_ready,
  input  bus_addr_t aw_addr,
  input  bus_id_t   aw_id,
  // write data channel
  input  logic      w_valid,
  output logic      w_ready,
  input  word_t     w_data,
  // write response channel
  output logic      b_valid,
  input  logic      b_ready,
  output bus_id_t   b_id,
  // read address channel
  input  logic      ar_valid,
  output logic      ar_ready,
  input  bus_addr_t ar_addr,
  input  bus_id_t   ar_id,
  // read data channel
  output logic      r_valid,
  input  logic      r_ready,
  output word_t     r_data,
  output bus_id_t   r_id,
  output logic      r_last,
  // host channels
  output logic      host_in_valid,
  input  logic      host_in_ready,
  output half_t     host_in_bits,
  input  logic      host_out_valid,
  output logic      host_out_ready,
  input  half_t     host_out_bits,
  output logic      cpu_reset
);
  logic  in_wr_en;
  word_t in_wr_data;
  logic  in_full;

  host_out_rd_if #(.DEPTH(DEPTH)) out_rd ();

  htif_reg_ctrl u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .aw_valid   (aw_valid),
    .aw_ready   (aw_ready),
    .aw_addr    (aw_addr),
    .aw_id      (aw_id),
    .w_valid    (w_valid),
    .w_ready    (w_ready),
    .w_data     (w_data),
    .b_valid    (b_valid),
    .b_ready    (b_ready),
    .b_id       (b_id),
    .ar_valid   (ar_valid),
    .ar_ready   (ar_ready),
    .ar_addr    (ar_addr),
    .ar_id      (ar_id),
    .r_valid    (r_valid),
    .r_ready    (r_ready),
    .r_data     (r_data),
    .r_id       (r_id),
    .r_last     (r_last),
    .in_wr_en   (in_wr_en),
    .in_wr_data (in_wr_data),
    .in_full    (in_full),
    .cpu_reset  (cpu_reset),
    .out_rd     (out_rd.ctrl)
  );

  host_in_unpacker #(.DEPTH(DEPTH)) u_host_in (
    .clk           (clk),
    .reset         (reset),
    .wr_en         (in_wr_en),
    .wr_data       (in_wr_data),
    .host_in_ready (host_in_ready),
    .full          (in_full),
    .host_in_valid (host_in_valid),
    .host_in_bits  (host_in_bits)
  );

  host_out_packer #(.DEPTH(DEPTH)) u_host_out (
    .clk            (clk),
    .reset          (reset),
    .host_out_valid (host_out_valid),
    .host_out_bits  (host_out_bits),
    .host_out_ready (host_out_ready),
    .rd             (out_rd.path)
  );
endmodule

// File: tb_htif_bridge.sv
module tb_htif_bridge
  import htif_bus_pkg::*, htif_host_pkg::*;
();
  localparam int DEPTH = 8;
  localparam int STALL_CYCLES = 20;

  // test lengths in bus or host operations
  localparam int LEN_HOST_IN = 6;
  localparam int LEN_HOST_OUT = 4 * DEPTH + 1;
  localparam int LEN_RESET = 11;
  localparam int LEN_BACKPRESSURE = DEPTH + 1 + STALL_CYCLES;
  localparam int LEN_ID_ECHO = 10;
  localparam int WATCHDOG_CYCLES =
    (LEN_HOST_IN + LEN_HOST_OUT + LEN_RESET + LEN_BACKPRESSURE + LEN_ID_ECHO) * 20;

  logic      clk = 1'b0;
  logic      reset;
  logic      aw_valid;
  logic      aw_ready;
  bus_addr_t aw_addr;
  bus_id_t   aw_id;
  logic      w_valid;
  logic      w_ready;
  word_t     w_data;
  logic      b_valid;
  logic      b_ready;
  bus_id_t   b_id;
  logic      ar_valid;
  logic      ar_ready;
  bus_addr_t ar_addr;
  bus_id_t   ar_id;
  logic      r_valid;
  logic      r_ready;
  word_t     r_data;
  bus_id_t   r_id;
  logic      r_last;
  logic      host_in_valid;
  logic      host_in_ready;
  half_t     host_in_bits;
  logic      host_out_valid;
  logic      host_out_ready;
  half_t     host_out_bits;
  logic      cpu_reset;

  // reference model
  half_t host_in_q [$];   // halves the host should receive, in order
  word_t host_out_q [$];  // words the bridge should hold
  half_t first_half = '0;
  logic  have_first = 1'b0;
  logic  hold_in = 1'b0;  // forces host_in_ready low

  string cur_test = "reset";
  int    errors = 0;
  int    errors_at_start = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  int    reset_pulses = 0;

  htif_bridge #(.DEPTH(DEPTH)) DUT (.*);

  always #50 clk = ~clk;

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      $display("[FAIL] %s: %s expected %h actual %h", cur_test, what, expected, actual);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond)
    else
    begin
      $display("%s: %s", cur_test, what);
      errors++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == errors_at_start)
      $display("test %s: ok", cur_test);
    else
    begin
      tests_failed++;
      $display("test %s: %0d errors", cur_test, errors - errors_at_start);
    end
  endtask

  task automatic start_write(input reg_sel_t sel, input word_t data);
    @(negedge clk);
    aw_valid = 1'b1;
    w_valid  = 1'b1;
    aw_addr  = {25'd0, sel, 2'b00};
    aw_id    = bus_id_t'($urandom);
    w_data   = data;
  endtask

  // ready is sampled mid-cycle, the transfer follows on the next rising edge
  task automatic finish_write(input reg_sel_t sel);
    bus_id_t id;
    id = aw_id;
    while (!aw_ready)
      @(negedge clk);
    check_true(w_ready, "w_ready low while aw_ready high");
    if (sel == REG_FIFO_WR)
    begin
      host_in_q.push_back(w_data[15:0]);  // low half goes out first
      host_in_q.push_back(w_data[31:16]);
    end
    @(negedge clk);
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    repeat ($urandom % 3) @(negedge clk);
    b_ready = 1'b1;
    while (!b_valid)
      @(negedge clk);
    check_value("b_id", 32'(id), 32'(b_id));
    @(negedge clk);
    b_ready = 1'b0;
  endtask

  task automatic bus_write(input reg_sel_t sel, input word_t data);
    start_write(sel, data);
    finish_write(sel);
  endtask

  task automatic bus_read(input reg_sel_t sel, output word_t data);
    bus_id_t id;
    @(negedge clk);
    id       = bus_id_t'($urandom);
    ar_valid = 1'b1;
    ar_addr  = {25'd0, sel, 2'b00};
    ar_id    = id;
    while (!ar_ready)
      @(negedge clk);
    @(negedge clk);
    ar_valid = 1'b0;
    repeat ($urandom % 3) @(negedge clk);
    r_ready = 1'b1;
    while (!r_valid)
      @(negedge clk);
    data = r_data;
    check_value("r_id", 32'(id), 32'(r_id));
    @(negedge clk);
    r_ready = 1'b0;
  endtask

  task automatic send_half(input half_t h);
    @(negedge clk);
    host_out_valid = 1'b1;
    host_out_bits  = h;
    while (!host_out_ready)
      @(negedge clk);
    if (have_first)
      host_out_q.push_back({h, first_half});
    else
      first_half = h;
    have_first = !have_first;
    @(negedge clk);
    host_out_valid = 1'b0;
    repeat ($urandom % 3) @(negedge clk);
  endtask

  task automatic wait_host_in_drained();
    while (host_in_q.size() != 0)
      @(negedge clk);
    repeat (4) @(negedge clk);
    check_true(!host_in_valid, "host_in_valid still high after all halves arrived");
  endtask

  // host side receiver with random ready
  initial
  begin
    half_t exp_half;
    host_in_ready = 1'b0;
    forever
    begin
      @(negedge clk);
      host_in_ready = !hold_in && ($urandom % 4 != 0);
      if (!reset && host_in_valid && host_in_ready)
      begin
        if (host_in_q.size() == 0)
          check_true(1'b0, "host-in half arrived that was never written");
        else
        begin
          exp_half = host_in_q.pop_front();
          check_value("host-in half", {16'd0, exp_half}, {16'd0, host_in_bits});
        end
      end
    end
  end

  always @(negedge clk)
  begin
    if (!reset)
    begin
      if (cpu_reset)
      begin
        reset_pulses++;
        check_true(w_ready, "cpu_reset high without w_ready");
      end
      if (r_valid)
        check_true(r_last, "r_last low during a read beat");
    end
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial
  begin
    int    n;
    int    pulses;
    word_t data;
    word_t exp_word;
    void'($urandom(32'he0e3));
    reset          = 1'b1;
    aw_valid       = 1'b0;
    aw_addr        = '0;
    aw_id          = '0;
    w_valid        = 1'b0;
    w_data         = '0;
    b_ready        = 1'b0;
    ar_valid       = 1'b0;
    ar_addr        = '0;
    ar_id          = '0;
    r_ready        = 1'b0;
    host_out_valid = 1'b0;
    host_out_bits  = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    begin_test("host_in_halves");
    n = 3 + int'($urandom % 4);
    for (int i = 0; i < n; i++)
      bus_write(REG_FIFO_WR, word_t'($urandom));
    wait_host_in_drained();
    end_test();

    begin_test("host_out_words");
    n = 2 * DEPTH;  // fills the queue
    for (int i = 0; i < n; i++)
      send_half(half_t'($urandom));
    check_value("host_out_ready", 32'(host_out_q.size() < DEPTH), 32'(host_out_ready));
    bus_read(REG_COUNT, data);
    check_value("word count", 32'(host_out_q.size()), data);
    while (host_out_q.size() != 0)
    begin
      exp_word = host_out_q.pop_front();
      bus_read(REG_FIFO_RD, data);
      check_value("packed word", exp_word, data);
      bus_read(REG_COUNT, data);
      check_value("word count after pop", 32'(host_out_q.size()), data);
      check_value("host_out_ready", 32'(host_out_q.size() < DEPTH), 32'(host_out_ready));
    end
    end_test();

    begin_test("reset_register");
    pulses = reset_pulses;
    bus_write(REG_RESET, word_t'($urandom));
    repeat (10) @(negedge clk);
    check_value("cpu_reset cycles", 32'(pulses + 1), 32'(reset_pulses));
    check_true(!host_in_valid, "host-in half appeared after the reset write");
    end_test();

    begin_test("back_pressure");
    hold_in = 1'b1;
    @(negedge clk);
    for (int i = 0; i < DEPTH; i++)
      bus_write(REG_FIFO_WR, word_t'($urandom));
    start_write(REG_FIFO_WR, word_t'($urandom));
    repeat (STALL_CYCLES)
    begin
      @(negedge clk);
      check_true(!aw_ready && !b_valid, "write accepted while the host-in queue was full");
    end
    hold_in = 1'b0;
    finish_write(REG_FIFO_WR);  // its halves are last in the model queue
    wait_host_in_drained();
    end_test();

    begin_test("id_echo");
    pulses = reset_pulses;
    for (int i = 0; i < LEN_ID_ECHO; i++)
    begin
      case ($urandom % 3)
        0: bus_write(REG_FIFO_WR, word_t'($urandom));
        1: bus_write(reg_sel_t'(1 + $urandom % 30), word_t'($urandom));  // unmapped
        default:
        begin
          bus_read(REG_COUNT, data);
          check_value("word count", 32'(host_out_q.size()), data);
        end
      endcase
    end
    wait_host_in_drained();
    check_value("cpu_reset cycles", 32'(pulses), 32'(reset_pulses));
    end_test();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end
endmodule

// File: htif_bridge.f
htif_bus_pkg.sv
htif_host_pkg.sv
host_out_rd_if.sv
sync_fifo.sv
host_in_unpacker.sv
host_out_packer.sv
htif_reg_ctrl.sv
htif_bridge.sv
tb_htif_bridge.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_htif_bridge
FILELIST  ?= htif_bridge.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
